// File: verilog.f
rtl/mips_isa_pkg.sv
rtl/pipeline_pkg.sv
rtl/control_unit.sv
rtl/register_bank.sv
rtl/hazard_unit.sv
rtl/decode_resolver.sv
rtl/decode_stage.sv
bench/decode_stage_checker.sv
bench/decode_stage_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module decode_stage_tb -f verilog.f
	./obj_dir/Vdecode_stage_tb | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

	localparam int RESET_CYCLES   = 8;
	localparam int REGFILE_STEPS  = 40;   // Write-back then R-type reads
	localparam int RANDOM_STEPS   = 300;  // Mixed decode
	localparam int BRANCH_STEPS   = 60;
	localparam int DIRECTED_STEPS = 7;    // Load-use and halt
	localparam int CYCLE_LIMIT    = RESET_CYCLES + REGFILE_STEPS + RANDOM_STEPS + BRANCH_STEPS
		+ DIRECTED_STEPS + 50;

	logic                  i_clock, i_reset, i_enable, i_wb_write, i_forward_a, i_forward_b;
	logic [31:0]           i_instruction, i_pc, i_wb_data, i_forward_data;
	logic [4:0]            i_wb_addr;
	pipeline_pkg::id_ex_t  o_id_ex;
	pipeline_pkg::pc_src_e o_pc_src;
	logic [31:0]           o_pc_target;
	logic                  o_pc_write, o_if_id_write, o_halt;

	logic [31:0]          model_regs [32];  // Register bank model
	pipeline_pkg::id_ex_t exp_bundle;       // Expected ID/EX content
	logic [15:0]          lfsr_state;
	int                   errors;
	int                   checks;
	int                   cycles;

	decode_stage decode_stage_i (.*);

	always #2 i_clock = ~i_clock;  // 4 ns period

	always @(posedge i_clock)
	begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [31:0] rand_bits(input int width);
		logic [31:0] value;
		logic        feedback;
		value = '0;
		for (int i = 0; i < width; i++)
		begin
			feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], feedback};  // One step per bit
			value      = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic logic [31:0] model_read(input logic [4:0] addr);
		if (addr == 5'd0)
			return '0;                           // r0 fixed
		if (i_wb_write && (addr == i_wb_addr))
			return i_wb_data;                    // Same-cycle write seen
		return model_regs[addr];
	endfunction

	function automatic pipeline_pkg::id_ex_t model_bundle(input logic [31:0] instr,
		input logic stall, input logic [31:0] data_a, input logic [31:0] data_b);
		pipeline_pkg::id_ex_t b;
		b = '0;
		if (i_enable && !stall)                  // Idle or bubble keeps zero controls
		begin
			case (instr[31:26])
				mips_isa_pkg::OP_RTYPE:
				begin
					b.ex.reg_dst_rd = 1'b1;
					b.wb.reg_write  = 1'b1;
					case (instr[5:0])
						mips_isa_pkg::FN_ADD: b.ex.alu_op = pipeline_pkg::ALU_ADD;
						mips_isa_pkg::FN_SUB: b.ex.alu_op = pipeline_pkg::ALU_SUB;
						mips_isa_pkg::FN_AND: b.ex.alu_op = pipeline_pkg::ALU_AND;
						mips_isa_pkg::FN_OR:  b.ex.alu_op = pipeline_pkg::ALU_OR;
						mips_isa_pkg::FN_SLT: b.ex.alu_op = pipeline_pkg::ALU_SLT;
						default:
						begin
							b.ex.alu_op    = pipeline_pkg::ALU_NOP;  // Unknown funct writes nothing
							b.wb.reg_write = 1'b0;
						end
					endcase
				end
				mips_isa_pkg::OP_ADDI:
				begin
					b.ex = '{pipeline_pkg::ALU_ADD, 1'b1, 1'b0};
					b.wb = '{1'b1, 1'b0};
				end
				mips_isa_pkg::OP_LW:
				begin
					b.ex  = '{pipeline_pkg::ALU_ADD, 1'b1, 1'b0};
					b.mem = '{1'b1, 1'b0};
					b.wb  = '{1'b1, 1'b1};           // Load data to rt
				end
				mips_isa_pkg::OP_SW:
				begin
					b.ex  = '{pipeline_pkg::ALU_ADD, 1'b1, 1'b0};
					b.mem = '{1'b0, 1'b1};
				end
				mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE: b.ex.alu_op = pipeline_pkg::ALU_SUB;
				default: b.ex.alu_op = pipeline_pkg::ALU_ADD;  // J, HALT, unknown
			endcase
		end
		b.operand_a = data_a;                    // Bank data, never forwarded
		b.operand_b = data_b;
		b.imm_ext   = {{16{instr[15]}}, instr[15:0]};
		b.rs        = instr[25:21];
		b.rt        = instr[20:16];
		b.rd        = instr[15:11];
		b.shamt     = instr[10:6];
		b.funct     = instr[5:0];
		b.halt      = i_enable && (instr[31:26] == mips_isa_pkg::OP_HALT);
		return b;
	endfunction

	function automatic logic [31:0] random_instruction();
		logic [31:0] r;
		logic [5:0]  op;
		logic [5:0]  fn;
		r = rand_bits(4);
		case (r[3:0])                            // Weighted opcode pick
			4'd0, 4'd1, 4'd2, 4'd3: op = mips_isa_pkg::OP_RTYPE;
			4'd4, 4'd5:             op = mips_isa_pkg::OP_ADDI;
			4'd6, 4'd7:             op = mips_isa_pkg::OP_LW;
			4'd8:                   op = mips_isa_pkg::OP_SW;
			4'd9, 4'd10:            op = mips_isa_pkg::OP_BEQ;
			4'd11, 4'd12:           op = mips_isa_pkg::OP_BNE;
			4'd13:                  op = mips_isa_pkg::OP_J;
			4'd14:                  op = mips_isa_pkg::OP_HALT;
			default:                op = 6'h11;  // Unassigned opcode
		endcase
		r = rand_bits(3);
		case (r[2:0])
			3'd0:    fn = mips_isa_pkg::FN_ADD;
			3'd1:    fn = mips_isa_pkg::FN_SUB;
			3'd2:    fn = mips_isa_pkg::FN_AND;
			3'd3:    fn = mips_isa_pkg::FN_OR;
			3'd4:    fn = mips_isa_pkg::FN_SLT;
			default: fn = 6'h27;                 // Not decoded
		endcase
		r = rand_bits(26);
		if (op == mips_isa_pkg::OP_RTYPE)
			return {op, r[25:6], fn};
		return {op, r[25:0]};
	endfunction

	task automatic check(input string name, input logic [191:0] expected,
		input logic [191:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// Drives one instruction and checks both the same-cycle outputs and the bundle before it
	task automatic step(input string name, input logic [31:0] instr, input logic enable,
		input logic wb_write, input logic [4:0] wb_addr, input logic [1:0] fwd);
		logic [31:0]           data_a;
		logic [31:0]           data_b;
		logic [31:0]           cmp_a;
		logic [31:0]           cmp_b;
		logic [31:0]           pc4;
		logic [31:0]           target;
		logic [5:0]            op;
		logic                  stall;
		pipeline_pkg::pc_src_e src;
		@(posedge i_clock);
		i_instruction  <= instr;
		i_pc           <= rand_bits(30) << 2;  // Word aligned
		i_enable       <= enable;
		i_wb_write     <= wb_write;
		i_wb_addr      <= wb_addr;
		i_wb_data      <= rand_bits(32);
		i_forward_a    <= fwd[1];
		i_forward_b    <= fwd[0];
		i_forward_data <= rand_bits(32);
		@(negedge i_clock);
		check({name, " bundle"}, 192'(exp_bundle), 192'(o_id_ex));
		check({name, " halt"}, 192'(exp_bundle.halt), 192'(o_halt));
		op     = instr[31:26];
		data_a = model_read(instr[25:21]);
		data_b = model_read(instr[20:16]);
		stall  = (exp_bundle.mem.mem_read && (exp_bundle.rt != 5'd0) &&
			((exp_bundle.rt == instr[25:21]) || (exp_bundle.rt == instr[20:16]))) ||
			(enable && (op == mips_isa_pkg::OP_HALT));
		cmp_a  = i_forward_a ? i_forward_data : data_a;
		cmp_b  = i_forward_b ? i_forward_data : data_b;
		pc4    = i_pc + 32'd4;
		src    = pipeline_pkg::PC_SEQ;
		if (enable && !stall && (op == mips_isa_pkg::OP_J))
			src = pipeline_pkg::PC_JUMP;
		else if (enable && !stall && (op == mips_isa_pkg::OP_BEQ) && (cmp_a == cmp_b))
			src = pipeline_pkg::PC_BRANCH;
		else if (enable && !stall && (op == mips_isa_pkg::OP_BNE) && (cmp_a != cmp_b))
			src = pipeline_pkg::PC_BRANCH;
		target = (enable && (op == mips_isa_pkg::OP_J)) ? {pc4[31:28], instr[25:0], 2'b00} :
			pc4 + {{14{instr[15]}}, instr[15:0], 2'b00};
		check({name, " pc_src"}, 192'(src), 192'(o_pc_src));
		check({name, " pc_target"}, 192'(target), 192'(o_pc_target));
		check({name, " pc_write"}, 192'(!stall), 192'(o_pc_write));
		check({name, " if_id_write"}, 192'(!stall), 192'(o_if_id_write));
		exp_bundle = model_bundle(instr, stall, data_a, data_b);
		if (wb_write && (wb_addr != 5'd0))
			model_regs[wb_addr] = i_wb_data;     // Lands at the coming edge
	endtask

	initial
	begin
		logic [31:0] instr;
		logic [31:0] r;
		i_clock        = 1'b0;
		i_reset        = 1'b1;
		i_instruction  = '0;
		i_pc           = '0;
		i_enable       = 1'b0;
		i_wb_write     = 1'b0;
		i_wb_addr      = '0;
		i_wb_data      = '0;
		i_forward_a    = 1'b0;
		i_forward_b    = 1'b0;
		i_forward_data = '0;
		lfsr_state     = 16'd4807;
		errors         = 0;
		checks         = 0;
		cycles         = 0;
		exp_bundle     = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		repeat (RESET_CYCLES) @(posedge i_clock);
		i_reset <= 1'b0;
		@(negedge i_clock);
		check("reset bundle", 192'(1'b0), 192'(o_id_ex));
		check("reset halt", 192'(1'b0), 192'(o_halt));
		check("reset pc_write", 192'(1'b1), 192'(o_pc_write));
		check("reset if_id_write", 192'(1'b1), 192'(o_if_id_write));
		for (int i = 0; i < REGFILE_STEPS; i++)
		begin
			r     = rand_bits(15);
			instr = {mips_isa_pkg::OP_RTYPE, r[14:5], r[4:0], 5'd0, mips_isa_pkg::FN_ADD};
			r     = rand_bits(7);                // A quarter write the rs being read
			step("regfile", instr, 1'b1, 1'b1, (r[1:0] == 2'd0) ? instr[25:21] : r[6:2], 2'b00);
		end
		for (int i = 0; i < RANDOM_STEPS; i++)
		begin
			instr = random_instruction();
			r     = rand_bits(11);
			step("decode", instr, r[2:0] != 3'd0, r[3], r[8:4], r[10:9]);
		end
		for (int i = 0; i < BRANCH_STEPS; i++)
		begin
			instr        = random_instruction();
			r            = rand_bits(5);
			instr[31:26] = (r[1:0] == 2'd0) ? mips_isa_pkg::OP_J :
				(r[1] ? mips_isa_pkg::OP_BNE : mips_isa_pkg::OP_BEQ);
			if (r[2])
				instr[20:16] = instr[25:21];       // Equal operands unless forwarded
			step("branch", instr, 1'b1, 1'b0, 5'd0, r[4:3]);
		end
		step("load_use lw", {mips_isa_pkg::OP_LW, 5'd3, 5'd7, 16'h0010}, 1'b1, 1'b0, 5'd0, 2'b00);
		instr = {mips_isa_pkg::OP_RTYPE, 5'd7, 5'd2, 5'd9, 5'd0, mips_isa_pkg::FN_ADD};
		step("load_use reader", instr, 1'b1, 1'b0, 5'd0, 2'b00);
		check("load_use pc_write", 192'(1'b0), 192'(o_pc_write));
		step("load_use held", instr, 1'b1, 1'b0, 5'd0, 2'b00);  // IF/ID repeats the reader
		check("load_use bubble", 192'(1'b0), 192'({o_id_ex.ex, o_id_ex.mem, o_id_ex.wb}));
		step("load_use r0 lw", {mips_isa_pkg::OP_LW, 5'd3, 5'd0, 16'h0004}, 1'b1, 1'b0, 5'd0,
			2'b00);
		step("load_use r0 reader", {mips_isa_pkg::OP_RTYPE, 5'd0, 5'd0, 5'd9, 5'd0,
			mips_isa_pkg::FN_ADD}, 1'b1, 1'b0, 5'd0, 2'b00);
		check("load_use r0 pc_write", 192'(1'b1), 192'(o_pc_write));
		step("halt", {mips_isa_pkg::OP_HALT, 26'd0}, 1'b1, 1'b0, 5'd0, 2'b00);
		check("halt pc_write", 192'(1'b0), 192'(o_pc_write));
		step("halt next", 32'd0, 1'b1, 1'b0, 5'd0, 2'b00);
		check("halt output", 192'(1'b1), 192'(o_halt));
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/decode_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_checker
(
	input wire logic                  i_clock,
	input wire logic                  i_reset,
	input wire logic                  i_pc_write,     // Low while stalled
	input wire pipeline_pkg::pc_src_e i_pc_src,
	input wire pipeline_pkg::id_ex_t  i_id_ex         // Registered bundle
);

	logic controls_zero;  // Bundle holds a bubble

	assign controls_zero = (i_id_ex.ex == '0) && (i_id_ex.mem == '0) && (i_id_ex.wb == '0);

	stall_bubble: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_pc_write |=> controls_zero)                    // Bubble follows a stall
		else $error("Bundle after a stall carries controls");

	reset_clear: assert property (@(posedge i_clock)
		i_reset |=> controls_zero)
		else $error("Bundle after reset carries controls");

	stall_seq: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_pc_write |-> (i_pc_src == pipeline_pkg::PC_SEQ))  // No redirect while held
		else $error("Next-PC source is not sequential during a stall");

endmodule

bind decode_stage decode_stage_checker decode_stage_checker_i (
	.i_clock       (i_clock),
	.i_reset       (i_reset),
	.i_pc_write    (o_pc_write),
	.i_pc_src      (o_pc_src),
	.i_id_ex       (o_id_ex)
);

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
(
	input  wire logic                                    i_clock,
	input  wire logic                                    i_reset,         // Synchronous, active high
	input  wire logic [mips_isa_pkg::DATA_WIDTH-1:0]     i_instruction,   // From IF/ID
	input  wire logic [mips_isa_pkg::DATA_WIDTH-1:0]     i_pc,
	input  wire logic                                    i_enable,        // Low idles the stage
	input  wire logic                                    i_wb_write,      // Write-back port
	input  wire logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0] i_wb_addr,
	input  wire logic [mips_isa_pkg::DATA_WIDTH-1:0]     i_wb_data,
	input  wire logic                                    i_forward_a,     // Forward selects
	input  wire logic                                    i_forward_b,
	input  wire logic [mips_isa_pkg::DATA_WIDTH-1:0]     i_forward_data,
	output pipeline_pkg::id_ex_t                         o_id_ex,         // ID/EX latch
	output pipeline_pkg::pc_src_e                        o_pc_src,
	output logic      [mips_isa_pkg::DATA_WIDTH-1:0]     o_pc_target,
	output logic                                         o_pc_write,
	output logic                                         o_if_id_write,
	output logic                                         o_halt           // Registered HALT
);

	logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0] rs;             // Source specifiers
	logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0] rt;
	mips_isa_pkg::opcode_e                   opcode;
	mips_isa_pkg::funct_e                    funct;
	pipeline_pkg::ex_ctrl_t                  ex_ctrl;        // Decoded controls
	pipeline_pkg::mem_ctrl_t                 mem_ctrl;
	pipeline_pkg::wb_ctrl_t                  wb_ctrl;
	pipeline_pkg::branch_kind_e              branch_kind;
	logic                                    is_halt;
	logic [mips_isa_pkg::DATA_WIDTH-1:0]     read_data_a;    // Bank outputs
	logic [mips_isa_pkg::DATA_WIDTH-1:0]     read_data_b;
	logic                                    stall;

	assign rs     = i_instruction[mips_isa_pkg::RS_MSB:mips_isa_pkg::RS_LSB];
	assign rt     = i_instruction[mips_isa_pkg::RT_MSB:mips_isa_pkg::RT_LSB];
	assign opcode = mips_isa_pkg::opcode_e'(
		i_instruction[mips_isa_pkg::OPCODE_MSB:mips_isa_pkg::OPCODE_LSB]);
	assign funct  = mips_isa_pkg::funct_e'(
		i_instruction[mips_isa_pkg::FUNCT_MSB:mips_isa_pkg::FUNCT_LSB]);
	assign o_halt = o_id_ex.halt;

	control_unit control_unit_i (
		.i_enable      (i_enable),
		.i_opcode      (opcode),
		.i_funct       (funct),
		.o_ex_ctrl     (ex_ctrl),
		.o_mem_ctrl    (mem_ctrl),
		.o_wb_ctrl     (wb_ctrl),
		.o_branch_kind (branch_kind),
		.o_is_halt     (is_halt)
	);

	register_bank register_bank_i (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_write       (i_wb_write),
		.i_write_addr  (i_wb_addr),
		.i_write_data  (i_wb_data),
		.i_read_addr_a (rs),
		.i_read_addr_b (rt),
		.o_read_data_a (read_data_a),
		.o_read_data_b (read_data_b)
	);

	hazard_unit hazard_unit_i (
		.i_rs          (rs),
		.i_rt          (rt),
		.i_id_ex       (o_id_ex),       // Compared against the instruction ahead
		.i_is_halt     (is_halt),
		.o_stall       (stall),
		.o_pc_write    (o_pc_write),
		.o_if_id_write (o_if_id_write)
	);

	decode_resolver decode_resolver_i (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_instruction  (i_instruction),
		.i_pc           (i_pc),
		.i_ex_ctrl      (ex_ctrl),
		.i_mem_ctrl     (mem_ctrl),
		.i_wb_ctrl      (wb_ctrl),
		.i_branch_kind  (branch_kind),
		.i_is_halt      (is_halt),
		.i_read_data_a  (read_data_a),
		.i_read_data_b  (read_data_b),
		.i_forward_a    (i_forward_a),
		.i_forward_b    (i_forward_b),
		.i_forward_data (i_forward_data),
		.i_stall        (stall),
		.o_pc_src       (o_pc_src),
		.o_pc_target    (o_pc_target),
		.o_id_ex        (o_id_ex)
	);

endmodule

`default_nettype wire

// File: rtl/decode_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module decode_resolver
(
	input  wire logic                                i_clock,
	input  wire logic                                i_reset,         // Clears the ID/EX latch
	input  wire logic [mips_isa_pkg::DATA_WIDTH-1:0] i_instruction,   // Instruction in ID
	input  wire logic [mips_isa_pkg::DATA_WIDTH-1:0] i_pc,            // Its PC
	input  pipeline_pkg::ex_ctrl_t                   i_ex_ctrl,
	input  pipeline_pkg::mem_ctrl_t                  i_mem_ctrl,
	input  pipeline_pkg::wb_ctrl_t                   i_wb_ctrl,
	input  pipeline_pkg::branch_kind_e               i_branch_kind,
	input  wire logic                                i_is_halt,
	input  wire logic [mips_isa_pkg::DATA_WIDTH-1:0] i_read_data_a,   // rs from bank
	input  wire logic [mips_isa_pkg::DATA_WIDTH-1:0] i_read_data_b,   // rt from bank
	input  wire logic                                i_forward_a,     // Use EX/MEM for a
	input  wire logic                                i_forward_b,     // Use EX/MEM for b
	input  wire logic [mips_isa_pkg::DATA_WIDTH-1:0] i_forward_data,  // EX/MEM result
	input  wire logic                                i_stall,         // Hazard bubble
	output pipeline_pkg::pc_src_e                    o_pc_src,        // Next-PC select
	output logic      [mips_isa_pkg::DATA_WIDTH-1:0] o_pc_target,     // Branch or jump target
	output pipeline_pkg::id_ex_t                     o_id_ex          // Registered bundle
);

	logic [mips_isa_pkg::DATA_WIDTH-1:0]  cmp_a;          // Branch compare operands
	logic [mips_isa_pkg::DATA_WIDTH-1:0]  cmp_b;
	logic                                 operands_equal;
	logic [mips_isa_pkg::DATA_WIDTH-1:0]  imm_ext;
	logic [mips_isa_pkg::DATA_WIDTH-1:0]  pc_plus4;
	logic [mips_isa_pkg::DATA_WIDTH-1:0]  branch_target;
	logic [mips_isa_pkg::DATA_WIDTH-1:0]  jump_target;
	logic [mips_isa_pkg::IMM_WIDTH-1:0]   imm;
	logic [mips_isa_pkg::INDEX_WIDTH-1:0] index;
	pipeline_pkg::id_ex_t                 id_ex_q;

	assign imm   = i_instruction[mips_isa_pkg::IMM_MSB:mips_isa_pkg::IMM_LSB];
	assign index = i_instruction[mips_isa_pkg::INDEX_MSB:mips_isa_pkg::INDEX_LSB];

	assign imm_ext = {{(mips_isa_pkg::DATA_WIDTH - mips_isa_pkg::IMM_WIDTH){imm[
		mips_isa_pkg::IMM_WIDTH-1]}}, imm};                        // Sign extension

	assign cmp_a          = i_forward_a ? i_forward_data : i_read_data_a;
	assign cmp_b          = i_forward_b ? i_forward_data : i_read_data_b;
	assign operands_equal = (cmp_a == cmp_b);

	assign pc_plus4      = i_pc + 32'd4;
	assign branch_target = pc_plus4 + {imm_ext[mips_isa_pkg::DATA_WIDTH-3:0], 2'b00};
	assign jump_target   = {pc_plus4[31:28], index, 2'b00};      // Region of PC plus 4
	assign o_pc_target   = (i_branch_kind == pipeline_pkg::BR_JUMP) ? jump_target : branch_target;

	always_comb
	begin
		o_pc_src = pipeline_pkg::PC_SEQ;      // Stall keeps the sequential path
		if (!i_stall)
		begin
			case (i_branch_kind)
				pipeline_pkg::BR_EQ:
					if (operands_equal)
						o_pc_src = pipeline_pkg::PC_BRANCH;
				pipeline_pkg::BR_NE:
					if (!operands_equal)
						o_pc_src = pipeline_pkg::PC_BRANCH;
				pipeline_pkg::BR_JUMP: o_pc_src = pipeline_pkg::PC_JUMP;
				default:               o_pc_src = pipeline_pkg::PC_SEQ;
			endcase
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			id_ex_q <= '0;
		end
		else
		begin
			id_ex_q.ex        <= i_stall ? '0 : i_ex_ctrl;  // Bubble on stall
			id_ex_q.mem       <= i_stall ? '0 : i_mem_ctrl;
			id_ex_q.wb        <= i_stall ? '0 : i_wb_ctrl;
			id_ex_q.operand_a <= i_read_data_a;             // Unforwarded bank data
			id_ex_q.operand_b <= i_read_data_b;
			id_ex_q.imm_ext   <= imm_ext;
			id_ex_q.rs        <= i_instruction[mips_isa_pkg::RS_MSB:mips_isa_pkg::RS_LSB];
			id_ex_q.rt        <= i_instruction[mips_isa_pkg::RT_MSB:mips_isa_pkg::RT_LSB];
			id_ex_q.rd        <= i_instruction[mips_isa_pkg::RD_MSB:mips_isa_pkg::RD_LSB];
			id_ex_q.shamt     <= i_instruction[mips_isa_pkg::SHAMT_MSB:mips_isa_pkg::SHAMT_LSB];
			id_ex_q.funct     <= i_instruction[mips_isa_pkg::FUNCT_MSB:mips_isa_pkg::FUNCT_LSB];
			id_ex_q.halt      <= i_is_halt;                 // Loads even when stalled
		end
	end

	assign o_id_ex = id_ex_q;

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
(
	input  wire logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0] i_rs,           // Current rs
	input  wire logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0] i_rt,           // Current rt
	input  pipeline_pkg::id_ex_t                         i_id_ex,        // Instruction ahead
	input  wire logic                                    i_is_halt,      // HALT in ID
	output logic                                         o_stall,        // Hold and bubble
	output logic                                         o_pc_write,     // PC may advance
	output logic                                         o_if_id_write   // IF/ID may load
);

	logic load_use;  // Load result needed too early

	// A load to r0 never creates a dependency
	assign load_use = i_id_ex.mem.mem_read && (i_id_ex.rt != '0) &&
		((i_id_ex.rt == i_rs) || (i_id_ex.rt == i_rt));

	assign o_stall       = load_use || i_is_halt;  // HALT freezes fetch
	assign o_pc_write    = !o_stall;
	assign o_if_id_write = !o_stall;                // Same hold as the PC

endmodule

`default_nettype wire

// File: rtl/register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module register_bank
(
	input  wire logic                                    i_clock,
	input  wire logic                                    i_reset,        // Clears every register
	input  wire logic                                    i_write,        // Write-back enable
	input  wire logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0] i_write_addr,
	input  wire logic [mips_isa_pkg::DATA_WIDTH-1:0]     i_write_data,
	input  wire logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0] i_read_addr_a,  // rs
	input  wire logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0] i_read_addr_b,  // rt
	output logic      [mips_isa_pkg::DATA_WIDTH-1:0]     o_read_data_a,
	output logic      [mips_isa_pkg::DATA_WIDTH-1:0]     o_read_data_b
);

	logic [mips_isa_pkg::DATA_WIDTH-1:0] regs [mips_isa_pkg::NUM_REGS];  // Register storage

	// One read port, with r0 fixed and same-cycle write-through
	function automatic logic [mips_isa_pkg::DATA_WIDTH-1:0] read_port(
		input logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0] addr
	);
		if (addr == '0)
			return '0;                                   // r0 always zero
		else if (i_write && (addr == i_write_addr))
			return i_write_data;                         // Bypass new data
		else
			return regs[addr];
	endfunction

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			for (int i = 0; i < mips_isa_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (i_write && (i_write_addr != '0))    // Writes to r0 dropped
		begin
			regs[i_write_addr] <= i_write_data;
		end
	end

	always_comb
	begin
		o_read_data_a = read_port(i_read_addr_a);
		o_read_data_b = read_port(i_read_addr_b);
	end

endmodule

`default_nettype wire

// File: rtl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit
(
	input  wire logic                       i_enable,       // Stage active
	input  mips_isa_pkg::opcode_e           i_opcode,       // Primary opcode
	input  mips_isa_pkg::funct_e            i_funct,        // R-type function
	output pipeline_pkg::ex_ctrl_t          o_ex_ctrl,      // EX controls
	output pipeline_pkg::mem_ctrl_t         o_mem_ctrl,     // MEM controls
	output pipeline_pkg::wb_ctrl_t          o_wb_ctrl,      // WB controls
	output pipeline_pkg::branch_kind_e      o_branch_kind,  // Branch or jump type
	output logic                            o_is_halt       // HALT in ID
);

	always_comb
	begin
		o_ex_ctrl     = '0;                     // Idle or unknown gives all zeros
		o_mem_ctrl    = '0;
		o_wb_ctrl     = '0;
		o_branch_kind = pipeline_pkg::BR_NONE;
		o_is_halt     = 1'b0;
		if (i_enable)
		begin
			case (i_opcode)
				mips_isa_pkg::OP_RTYPE:
				begin
					o_ex_ctrl.reg_dst_rd = 1'b1;     // Result to rd
					o_wb_ctrl.reg_write  = 1'b1;
					case (i_funct)
						mips_isa_pkg::FN_ADD: o_ex_ctrl.alu_op = pipeline_pkg::ALU_ADD;
						mips_isa_pkg::FN_SUB: o_ex_ctrl.alu_op = pipeline_pkg::ALU_SUB;
						mips_isa_pkg::FN_AND: o_ex_ctrl.alu_op = pipeline_pkg::ALU_AND;
						mips_isa_pkg::FN_OR:  o_ex_ctrl.alu_op = pipeline_pkg::ALU_OR;
						mips_isa_pkg::FN_SLT: o_ex_ctrl.alu_op = pipeline_pkg::ALU_SLT;
						default:
						begin
							o_ex_ctrl.alu_op    = pipeline_pkg::ALU_NOP;  // Unknown funct
							o_wb_ctrl.reg_write = 1'b0;                   // Suppress write
						end
					endcase
				end
				mips_isa_pkg::OP_ADDI:
				begin
					o_ex_ctrl.alu_op      = pipeline_pkg::ALU_ADD;
					o_ex_ctrl.alu_src_imm = 1'b1;    // rs plus immediate
					o_wb_ctrl.reg_write   = 1'b1;    // Result to rt
				end
				mips_isa_pkg::OP_LW:
				begin
					o_ex_ctrl.alu_op      = pipeline_pkg::ALU_ADD;  // Address calculation
					o_ex_ctrl.alu_src_imm = 1'b1;
					o_mem_ctrl.mem_read   = 1'b1;
					o_wb_ctrl.reg_write   = 1'b1;
					o_wb_ctrl.mem_to_reg  = 1'b1;    // Load data to rt
				end
				mips_isa_pkg::OP_SW:
				begin
					o_ex_ctrl.alu_op      = pipeline_pkg::ALU_ADD;
					o_ex_ctrl.alu_src_imm = 1'b1;
					o_mem_ctrl.mem_write  = 1'b1;    // No register write
				end
				mips_isa_pkg::OP_BEQ:
				begin
					o_ex_ctrl.alu_op = pipeline_pkg::ALU_SUB;  // Compare only
					o_branch_kind    = pipeline_pkg::BR_EQ;
				end
				mips_isa_pkg::OP_BNE:
				begin
					o_ex_ctrl.alu_op = pipeline_pkg::ALU_SUB;
					o_branch_kind    = pipeline_pkg::BR_NE;
				end
				mips_isa_pkg::OP_J:    o_branch_kind = pipeline_pkg::BR_JUMP;
				mips_isa_pkg::OP_HALT: o_is_halt     = 1'b1;  // Controls stay zero
				default:               o_is_halt     = 1'b0;  // Unknown opcode
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/pipeline_pkg.sv
`default_nettype none

package pipeline_pkg;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,  // Also the value of a zeroed bundle
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4,
		ALU_NOP = 3'd7   // Unknown function code
	} alu_op_e;

	typedef enum logic [1:0] {
		PC_SEQ    = 2'd0,  // PC plus 4
		PC_BRANCH = 2'd1,  // Taken conditional branch
		PC_JUMP   = 2'd2   // Absolute jump
	} pc_src_e;

	typedef enum logic [1:0] {
		BR_NONE = 2'd0,
		BR_EQ   = 2'd1,  // BEQ
		BR_NE   = 2'd2,  // BNE
		BR_JUMP = 2'd3   // J
	} branch_kind_e;

	typedef struct packed {
		alu_op_e alu_op;       // Operation for EX
		logic    alu_src_imm;  // Operand b from immediate
		logic    reg_dst_rd;   // Destination is rd, else rt
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;   // Load
		logic mem_write;  // Store
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;   // Writes the register bank
		logic mem_to_reg;  // Result comes from memory
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t                                  ex;
		mem_ctrl_t                                 mem;
		wb_ctrl_t                                  wb;
		logic [mips_isa_pkg::DATA_WIDTH-1:0]       operand_a;  // rs contents
		logic [mips_isa_pkg::DATA_WIDTH-1:0]       operand_b;  // rt contents
		logic [mips_isa_pkg::DATA_WIDTH-1:0]       imm_ext;    // Sign-extended immediate
		logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0]   rs;
		logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0]   rt;
		logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0]   rd;
		logic [mips_isa_pkg::REG_ADDR_WIDTH-1:0]   shamt;
		logic [mips_isa_pkg::FUNCT_WIDTH-1:0]      funct;
		logic                                      halt;       // HALT reached ID/EX
	} id_ex_t;

endpackage

`default_nettype wire

// File: rtl/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	localparam int DATA_WIDTH     = 32;  // Datapath and instruction width
	localparam int OPCODE_WIDTH   = 6;   // Primary opcode field
	localparam int FUNCT_WIDTH    = 6;   // R-type function field
	localparam int IMM_WIDTH      = 16;  // I-type immediate
	localparam int INDEX_WIDTH    = 26;  // J-type word index
	localparam int NUM_REGS       = 32;  // Architectural registers
	localparam int REG_ADDR_WIDTH = 5;   // Register specifier width

	// Instruction field positions
	localparam int OPCODE_MSB = 31;
	localparam int OPCODE_LSB = 26;
	localparam int RS_MSB     = 25;  // First source
	localparam int RS_LSB     = 21;
	localparam int RT_MSB     = 20;  // Second source or I-type destination
	localparam int RT_LSB     = 16;
	localparam int RD_MSB     = 15;  // R-type destination
	localparam int RD_LSB     = 11;
	localparam int SHAMT_MSB  = 10;  // Shift amount
	localparam int SHAMT_LSB  = 6;
	localparam int FUNCT_MSB  = 5;
	localparam int FUNCT_LSB  = 0;
	localparam int IMM_MSB    = 15;
	localparam int IMM_LSB    = 0;
	localparam int INDEX_MSB  = 25;
	localparam int INDEX_LSB  = 0;

	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_RTYPE = 6'h00,  // Function field selects the operation
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2B,
		OP_HALT  = 6'h3F   // All ones stops the pipeline
	} opcode_e;

	typedef enum logic [FUNCT_WIDTH-1:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2A
	} funct_e;

endpackage

`default_nettype wire
